//--- udp_echo_settings.svh
//------------------------------------------------------------
// UDP echo core settings
// Echo port, probe size, UDP header size and FIFO depth
//------------------------------------------------------------
`ifndef UDP_ECHO_SETTINGS_SVH
`define UDP_ECHO_SETTINGS_SVH

// Destination port that selects echoing
`define ECHO_PORT 16'd1234

`define PROBE_LEN 12       // Probe payload bytes
`define UDP_HDR_BYTES 8    // UDP header size in bytes

// Default echo FIFO depth, power of two
`define FIFO_DEPTH 64

`endif

//--- udp_echo_pkg.sv
//------------------------------------------------------------
// UDP echo core package
// Field types, FSM state encodings and the probe text
//------------------------------------------------------------
`include "udp_echo_settings.svh"

package udp_echo_pkg;

    typedef logic [7:0]  byte_t;      // Payload byte
    typedef logic [31:0] ip_addr_t;   // IPv4 address
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;   // UDP length field, header included

    typedef enum logic [1:0] {
        FLT_IDLE,
        FLT_ECHO,
        FLT_DROP
    } filter_state_t;

    typedef enum logic [1:0] {
        PRB_IDLE,
        PRB_HDR,
        PRB_DATA,
        PRB_DONE
    } probe_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ECHO,
        ARB_PROBE
    } arb_state_t;

    // "cutoff check" in ASCII
    localparam byte_t PROBE_MESSAGE [0:`PROBE_LEN-1] = '{
        8'h63, 8'h75, 8'h74, 8'h6F, 8'h66, 8'h66,
        8'h20, 8'h63, 8'h68, 8'h65, 8'h63, 8'h6B
    };

endpackage

//--- echo_filter.sv
//------------------------------------------------------------
// Echo filter
// Classifies incoming datagrams by destination port, forwards
// echo payload to the FIFO, builds the swapped reply header
// and cuts off the receive path after the first echo
//------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module echo_filter import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Input header channel
    input  logic      s_udp_hdr_valid,
    output logic      s_udp_hdr_ready,
    input  ip_addr_t  s_udp_ip_source_ip,
    input  udp_port_t s_udp_source_port,
    input  udp_port_t s_udp_dest_port,
    input  udp_len_t  s_udp_length,
    // Input payload stream
    input  byte_t     s_udp_payload_tdata,
    input  logic      s_udp_payload_tvalid,
    output logic      s_udp_payload_tready,
    input  logic      s_udp_payload_tlast,
    input  logic      s_udp_payload_tuser,
    // Echo reply header
    output logic      echo_hdr_valid,
    input  logic      echo_hdr_ready,
    output ip_addr_t  echo_ip,
    output udp_port_t echo_src_port,
    output udp_port_t echo_dst_port,
    output udp_len_t  echo_length,
    // Echo payload into the FIFO
    output byte_t     fifo_in_tdata,
    output logic      fifo_in_tvalid,
    input  logic      fifo_in_tready,
    output logic      fifo_in_tlast,
    output logic      fifo_in_tuser,
    // Probe trigger
    output logic      probe_start,
    output ip_addr_t  probe_ip,
    output udp_port_t probe_src_port,
    output udp_port_t probe_dst_port
);

    filter_state_t state;
    logic          cutoff;      // Receive path closed after first echo
    logic          hdr_xfer;
    logic          is_echo;
    logic          pay_xfer;

    assign s_udp_hdr_ready = (state == FLT_IDLE);
    assign hdr_xfer = s_udp_hdr_valid && s_udp_hdr_ready;
    assign is_echo  = !cutoff && (s_udp_dest_port == `ECHO_PORT);
    assign pay_xfer = s_udp_payload_tvalid && s_udp_payload_tready;

    // Payload goes straight on to the FIFO
    assign fifo_in_tdata = s_udp_payload_tdata;
    assign fifo_in_tlast = s_udp_payload_tlast;
    assign fifo_in_tuser = s_udp_payload_tuser;

    always_comb begin
        fifo_in_tvalid = 1'b0;
        s_udp_payload_tready = 1'b0;
        case (state)
            FLT_ECHO: begin
                fifo_in_tvalid = s_udp_payload_tvalid;
                s_udp_payload_tready = fifo_in_tready;
            end
            FLT_DROP: s_udp_payload_tready = 1'b1;  // Drain and discard
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FLT_IDLE;
            cutoff <= 1'b0;
            echo_hdr_valid <= 1'b0;
            probe_start <= 1'b0;
        end else begin
            probe_start <= 1'b0;
            if (echo_hdr_valid && echo_hdr_ready) begin
                echo_hdr_valid <= 1'b0;
            end
            case (state)
                FLT_IDLE: begin
                    if (hdr_xfer) begin
                        state <= is_echo ? FLT_ECHO : FLT_DROP;
                        if (is_echo) echo_hdr_valid <= 1'b1;  // Pending header survives drops
                    end
                end
                FLT_ECHO: begin
                    if (pay_xfer && s_udp_payload_tlast) begin
                        state <= FLT_IDLE;
                        probe_start <= 1'b1;
                        cutoff <= 1'b1;
                    end
                end
                default: begin
                    if (pay_xfer && s_udp_payload_tlast) state <= FLT_IDLE;
                end
            endcase
        end
    end

    // Reply header, ports swapped
    always_ff @(posedge clk) begin
        if (hdr_xfer && is_echo) begin
            echo_ip <= s_udp_ip_source_ip;
            echo_src_port <= s_udp_dest_port;
            echo_dst_port <= s_udp_source_port;
            echo_length <= s_udp_length;
        end
    end

    // Probe goes to the same endpoint as the echo
    assign probe_ip = echo_ip;
    assign probe_src_port = echo_src_port;
    assign probe_dst_port = echo_dst_port;

endmodule

//--- probe_source.sv
//------------------------------------------------------------
// Probe source
// Sends one probe datagram with a fixed message to the
// endpoint of the first echo, then stays silent
//------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module probe_source import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      probe_start,
    input  ip_addr_t  probe_ip,
    input  udp_port_t probe_src_port,
    input  udp_port_t probe_dst_port,
    // Probe header
    output logic      probe_hdr_valid,
    input  logic      probe_hdr_ready,
    output ip_addr_t  probe_hdr_ip,
    output udp_port_t probe_hdr_src_port,
    output udp_port_t probe_hdr_dst_port,
    // Probe payload
    output byte_t     probe_payload_tdata,
    output logic      probe_payload_tvalid,
    input  logic      probe_payload_tready,
    output logic      probe_payload_tlast
);

    localparam int IDX_W = $clog2(`PROBE_LEN);

    probe_state_t     state;
    logic [IDX_W-1:0] idx;     // Current message byte

    assign probe_hdr_valid      = (state == PRB_HDR);
    assign probe_payload_tvalid = (state == PRB_DATA);
    assign probe_payload_tdata  = PROBE_MESSAGE[idx];
    assign probe_payload_tlast  = (idx == IDX_W'(`PROBE_LEN - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PRB_IDLE;
            idx <= '0;
        end else begin
            case (state)
                PRB_IDLE: if (probe_start) state <= PRB_HDR;
                PRB_HDR: begin
                    if (probe_hdr_ready) begin
                        state <= PRB_DATA;
                        idx <= '0;
                    end
                end
                PRB_DATA: begin
                    if (probe_payload_tready) begin
                        if (probe_payload_tlast) begin
                            state <= PRB_DONE;   // One shot only
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Latch the reply endpoint
    always_ff @(posedge clk) begin
        if (probe_start && state == PRB_IDLE) begin
            probe_hdr_ip <= probe_ip;
            probe_hdr_src_port <= probe_src_port;
            probe_hdr_dst_port <= probe_dst_port;
        end
    end

endmodule

//--- payload_fifo.sv
//------------------------------------------------------------
// Payload FIFO
// Synchronous byte FIFO carrying last and user flags
//------------------------------------------------------------
`timescale 1ns/1ps

module payload_fifo import udp_echo_pkg::*; #(
    parameter int DEPTH = 64   // Power of two
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_tdata,
    input  logic  in_tvalid,
    output logic  in_tready,
    input  logic  in_tlast,
    input  logic  in_tuser,
    output byte_t out_tdata,
    output logic  out_tvalid,
    input  logic  out_tready,
    output logic  out_tlast,
    output logic  out_tuser
);

    localparam int ADDR_W = $clog2(DEPTH);

    byte_t            data_mem [DEPTH];
    logic [1:0]       flag_mem [DEPTH];   // {tuser, tlast}
    logic [ADDR_W:0]  wr_ptr;
    logic [ADDR_W:0]  rd_ptr;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // Extra pointer bit tells full from empty
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign in_tready  = !full;
    assign out_tvalid = (wr_ptr != rd_ptr);
    assign wr_en = in_tvalid && in_tready;
    assign rd_en = out_tvalid && out_tready;

    assign out_tdata = data_mem[rd_ptr[ADDR_W-1:0]];
    assign out_tlast = flag_mem[rd_ptr[ADDR_W-1:0]][0];
    assign out_tuser = flag_mem[rd_ptr[ADDR_W-1:0]][1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr[ADDR_W-1:0]] <= in_tdata;
            flag_mem[wr_ptr[ADDR_W-1:0]] <= {in_tuser, in_tlast};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- reply_arbiter.sv
//------------------------------------------------------------
// Reply arbiter
// Puts echo and probe datagrams one at a time on the output
// channels and shows each first payload byte on the LEDs
//------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module reply_arbiter import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Echo header and payload
    input  logic      echo_hdr_valid,
    output logic      echo_hdr_ready,
    input  ip_addr_t  echo_ip,
    input  udp_port_t echo_src_port,
    input  udp_port_t echo_dst_port,
    input  udp_len_t  echo_length,
    input  byte_t     echo_payload_tdata,
    input  logic      echo_payload_tvalid,
    output logic      echo_payload_tready,
    input  logic      echo_payload_tlast,
    input  logic      echo_payload_tuser,
    // Probe header and payload
    input  logic      probe_hdr_valid,
    output logic      probe_hdr_ready,
    input  ip_addr_t  probe_hdr_ip,
    input  udp_port_t probe_hdr_src_port,
    input  udp_port_t probe_hdr_dst_port,
    input  byte_t     probe_payload_tdata,
    input  logic      probe_payload_tvalid,
    output logic      probe_payload_tready,
    input  logic      probe_payload_tlast,
    // Output header channel
    output logic      m_udp_hdr_valid,
    input  logic      m_udp_hdr_ready,
    output ip_addr_t  m_udp_ip_dest_ip,
    output udp_port_t m_udp_source_port,
    output udp_port_t m_udp_dest_port,
    output udp_len_t  m_udp_length,
    // Output payload stream
    output byte_t     m_udp_payload_tdata,
    output logic      m_udp_payload_tvalid,
    input  logic      m_udp_payload_tready,
    output logic      m_udp_payload_tlast,
    output logic      m_udp_payload_tuser,
    output byte_t     led
);

    localparam udp_len_t PROBE_UDP_LEN = udp_len_t'(`UDP_HDR_BYTES + `PROBE_LEN);

    arb_state_t state;
    logic       hdr_done;     // Header of granted datagram has left
    logic       first_beat;
    logic       sel_probe;
    logic       granted;
    logic       hdr_xfer;
    logic       pay_xfer;

    assign sel_probe = (state == ARB_PROBE);
    assign granted   = (state != ARB_IDLE);

    // Header first, then payload of the same source
    assign m_udp_hdr_valid = granted && !hdr_done &&
                             (sel_probe ? probe_hdr_valid : echo_hdr_valid);
    assign echo_hdr_ready  = (state == ARB_ECHO) && !hdr_done && m_udp_hdr_ready;
    assign probe_hdr_ready = sel_probe && !hdr_done && m_udp_hdr_ready;

    assign m_udp_ip_dest_ip  = sel_probe ? probe_hdr_ip : echo_ip;
    assign m_udp_source_port = sel_probe ? probe_hdr_src_port : echo_src_port;
    assign m_udp_dest_port   = sel_probe ? probe_hdr_dst_port : echo_dst_port;
    assign m_udp_length      = sel_probe ? PROBE_UDP_LEN : echo_length;

    assign m_udp_payload_tvalid = granted && hdr_done &&
                                  (sel_probe ? probe_payload_tvalid : echo_payload_tvalid);
    assign echo_payload_tready  = (state == ARB_ECHO) && hdr_done && m_udp_payload_tready;
    assign probe_payload_tready = sel_probe && hdr_done && m_udp_payload_tready;

    assign m_udp_payload_tdata = sel_probe ? probe_payload_tdata : echo_payload_tdata;
    assign m_udp_payload_tlast = sel_probe ? probe_payload_tlast : echo_payload_tlast;
    assign m_udp_payload_tuser = sel_probe ? 1'b0 : echo_payload_tuser;

    assign hdr_xfer = m_udp_hdr_valid && m_udp_hdr_ready;
    assign pay_xfer = m_udp_payload_tvalid && m_udp_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            hdr_done <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (echo_hdr_valid) state <= ARB_ECHO;      // Echo has priority
                    else if (probe_hdr_valid) state <= ARB_PROBE;
                end
                default: begin
                    if (hdr_xfer) hdr_done <= 1'b1;
                    if (pay_xfer && m_udp_payload_tlast) begin
                        state <= ARB_IDLE;
                        hdr_done <= 1'b0;
                    end
                end
            endcase
        end
    end

    // First payload byte of each datagram onto the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
            first_beat <= 1'b1;
        end else if (pay_xfer) begin
            if (first_beat) led <= m_udp_payload_tdata;
            first_beat <= m_udp_payload_tlast;
        end
    end

endmodule

//--- udp_echo_core.sv
//------------------------------------------------------------
// UDP echo core top level
// Echo filter, probe source, payload FIFO and reply arbiter
//------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module udp_echo_core import udp_echo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      s_udp_hdr_valid,
    output logic      s_udp_hdr_ready,
    input  ip_addr_t  s_udp_ip_source_ip,
    input  udp_port_t s_udp_source_port,
    input  udp_port_t s_udp_dest_port,
    input  udp_len_t  s_udp_length,
    input  byte_t     s_udp_payload_tdata,
    input  logic      s_udp_payload_tvalid,
    output logic      s_udp_payload_tready,
    input  logic      s_udp_payload_tlast,
    input  logic      s_udp_payload_tuser,
    output logic      m_udp_hdr_valid,
    input  logic      m_udp_hdr_ready,
    output ip_addr_t  m_udp_ip_dest_ip,
    output udp_port_t m_udp_source_port,
    output udp_port_t m_udp_dest_port,
    output udp_len_t  m_udp_length,
    output byte_t     m_udp_payload_tdata,
    output logic      m_udp_payload_tvalid,
    input  logic      m_udp_payload_tready,
    output logic      m_udp_payload_tlast,
    output logic      m_udp_payload_tuser,
    output byte_t     led
);

    logic      echo_hdr_valid, echo_hdr_ready;
    ip_addr_t  echo_ip;
    udp_port_t echo_src_port, echo_dst_port;
    udp_len_t  echo_length;
    byte_t     fifo_in_tdata, echo_payload_tdata;
    logic      fifo_in_tvalid, fifo_in_tready, fifo_in_tlast, fifo_in_tuser;
    logic      echo_payload_tvalid, echo_payload_tready;
    logic      echo_payload_tlast, echo_payload_tuser;
    logic      probe_start;
    ip_addr_t  probe_ip, probe_hdr_ip;
    udp_port_t probe_src_port, probe_dst_port;
    udp_port_t probe_hdr_src_port, probe_hdr_dst_port;
    logic      probe_hdr_valid, probe_hdr_ready;
    byte_t     probe_payload_tdata;
    logic      probe_payload_tvalid, probe_payload_tready, probe_payload_tlast;

    echo_filter filter_i (.*);

    probe_source probe_i (.*);

    payload_fifo #(
        .DEPTH(`FIFO_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (fifo_in_tdata),
        .in_tvalid  (fifo_in_tvalid),
        .in_tready  (fifo_in_tready),
        .in_tlast   (fifo_in_tlast),
        .in_tuser   (fifo_in_tuser),
        .out_tdata  (echo_payload_tdata),
        .out_tvalid (echo_payload_tvalid),
        .out_tready (echo_payload_tready),
        .out_tlast  (echo_payload_tlast),
        .out_tuser  (echo_payload_tuser)
    );

    reply_arbiter arbiter_i (.*);

endmodule

//--- udp_echo_properties.sv
//------------------------------------------------------------
// Reply arbiter properties
// Output handshake stability and header/payload ordering
//------------------------------------------------------------
`timescale 1ns/1ps

module udp_echo_properties import udp_echo_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      granted,
    input logic      m_udp_hdr_valid,
    input logic      m_udp_hdr_ready,
    input ip_addr_t  m_udp_ip_dest_ip,
    input udp_port_t m_udp_source_port,
    input udp_port_t m_udp_dest_port,
    input udp_len_t  m_udp_length,
    input byte_t     m_udp_payload_tdata,
    input logic      m_udp_payload_tvalid,
    input logic      m_udp_payload_tready,
    input logic      m_udp_payload_tlast,
    input logic      m_udp_payload_tuser
);

    int   prop_failures = 0;   // Number of failed properties
    logic in_datagram;         // Between a header transfer and its tlast
    logic hdr_xfer;
    logic pay_xfer;

    assign hdr_xfer = m_udp_hdr_valid && m_udp_hdr_ready;
    assign pay_xfer = m_udp_payload_tvalid && m_udp_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) in_datagram <= 1'b0;
        else if (hdr_xfer) in_datagram <= 1'b1;
        else if (pay_xfer && m_udp_payload_tlast) in_datagram <= 1'b0;
    end

    hdr_stable: assert property (@(posedge clk) disable iff (rst)
        m_udp_hdr_valid && !m_udp_hdr_ready |=> m_udp_hdr_valid &&
        $stable({m_udp_ip_dest_ip, m_udp_source_port, m_udp_dest_port, m_udp_length}))
    else begin
        $error("output header dropped or changed before ready");
        prop_failures++;
    end

    payload_stable: assert property (@(posedge clk) disable iff (rst)
        m_udp_payload_tvalid && !m_udp_payload_tready |=> m_udp_payload_tvalid &&
        $stable({m_udp_payload_tdata, m_udp_payload_tlast, m_udp_payload_tuser}))
    else begin
        $error("output payload dropped or changed before ready");
        prop_failures++;
    end

    one_hdr_per_datagram: assert property (@(posedge clk) disable iff (rst)
        in_datagram |-> granted && !hdr_xfer)
    else begin
        $error("grant lost or second header sent before tlast");
        prop_failures++;
    end

    payload_after_hdr: assert property (@(posedge clk) disable iff (rst)
        pay_xfer |-> in_datagram)
    else begin
        $error("payload transfer without a preceding header");
        prop_failures++;
    end

endmodule

//--- tb_udp_echo.sv
//------------------------------------------------------------
// UDP echo core testbench
// Drop, echo, probe and cutoff datagrams with random output
// back-pressure, scoreboard on the reply channels and LEDs
//------------------------------------------------------------
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module tb_udp_echo import udp_echo_pkg::*; ();

    localparam int NUM_DGRAMS = 5;
    localparam int MAX_LEN = 100;   // Longer than the echo FIFO
    localparam int TIMEOUT_CYCLES = NUM_DGRAMS * 200 + MAX_LEN;

    logic      clk = 1'b0;
    logic      rst;
    logic      s_udp_hdr_valid;
    logic      s_udp_hdr_ready;
    ip_addr_t  s_udp_ip_source_ip;
    udp_port_t s_udp_source_port;
    udp_port_t s_udp_dest_port;
    udp_len_t  s_udp_length;
    byte_t     s_udp_payload_tdata;
    logic      s_udp_payload_tvalid;
    logic      s_udp_payload_tready;
    logic      s_udp_payload_tlast;
    logic      s_udp_payload_tuser;
    logic      m_udp_hdr_valid;
    logic      m_udp_hdr_ready = 1'b0;
    ip_addr_t  m_udp_ip_dest_ip;
    udp_port_t m_udp_source_port;
    udp_port_t m_udp_dest_port;
    udp_len_t  m_udp_length;
    byte_t     m_udp_payload_tdata;
    logic      m_udp_payload_tvalid;
    logic      m_udp_payload_tready = 1'b0;
    logic      m_udp_payload_tlast;
    logic      m_udp_payload_tuser;
    byte_t     led;

    logic [31:0] data_rng = 32'd81920;
    logic [31:0] rdy_rng = 32'd81920;
    logic [79:0] exp_hdr_q[$];   // {ip, src port, dst port, length}
    string       exp_name_q[$];
    logic [9:0]  exp_pay_q[$];   // {tuser, tlast, tdata}
    string       cur_name = "none";
    byte_t       led_exp = '0;
    logic        led_check = 1'b0;
    logic        out_started = 1'b0;
    logic        reset_checked = 1'b0;
    int          value_errors = 0;
    int          proto_errors = 0;

    udp_echo_core dut_i (.*);

    bind reply_arbiter udp_echo_properties props_i (
        .clk,
        .rst,
        .granted,
        .m_udp_hdr_valid,
        .m_udp_hdr_ready,
        .m_udp_ip_dest_ip,
        .m_udp_source_port,
        .m_udp_dest_port,
        .m_udp_length,
        .m_udp_payload_tdata,
        .m_udp_payload_tvalid,
        .m_udp_payload_tready,
        .m_udp_payload_tlast,
        .m_udp_payload_tuser
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] random_word();
        data_rng = xorshift32(data_rng);
        return data_rng;
    endfunction

    function automatic int random_length();
        return 1 + int'(random_word() % 32'd40);
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s %s: expected %0h actual %0h", name, field, exp, act);
            value_errors++;
        end
    endtask

    // Ready only moves 2 ns after the edge, so the negedge sees the final value
    task automatic complete_transfer(input logic payload);
        @(negedge clk);
        while (!(payload ? s_udp_payload_tready : s_udp_hdr_ready)) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic send_datagram(input string name, input udp_port_t dport, input ip_addr_t ip,
                                 input udp_port_t sport, input int len, input logic echoed);
        logic [31:0] r;
        if (echoed) begin
            exp_hdr_q.push_back({ip, dport, sport, udp_len_t'(len + `UDP_HDR_BYTES)});
            exp_name_q.push_back(name);
        end
        s_udp_hdr_valid = 1'b1;
        s_udp_ip_source_ip = ip;
        s_udp_source_port = sport;
        s_udp_dest_port = dport;
        s_udp_length = udp_len_t'(len + `UDP_HDR_BYTES);
        complete_transfer(1'b0);
        s_udp_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            r = random_word();
            s_udp_payload_tdata = r[7:0];
            s_udp_payload_tlast = (i == len - 1);
            s_udp_payload_tuser = r[8];   // Random user flag on every beat
            s_udp_payload_tvalid = 1'b1;
            if (echoed) exp_pay_q.push_back({s_udp_payload_tuser, s_udp_payload_tlast, r[7:0]});
            complete_transfer(1'b1);
        end
        s_udp_payload_tvalid = 1'b0;
        s_udp_payload_tlast = 1'b0;
        s_udp_payload_tuser = 1'b0;
    endtask

    // Random back-pressure on both output channels
    always @(posedge clk) begin
        #2;
        rdy_rng = xorshift32(rdy_rng);
        m_udp_hdr_ready = rdy_rng[17:16] != 2'b00;
        m_udp_payload_tready = rdy_rng[25:24] == 2'b00;   // Mostly stalled, echo FIFO fills up
    end

    // Scoreboard, transfers seen half a cycle before their edge
    always @(negedge clk) begin
        logic [79:0] eh;
        logic [9:0]  ep;
        if (!rst) begin
            if (!reset_checked) begin
                check_value("reset", "s_hdr_ready", 32'd1, 32'(s_udp_hdr_ready));
                check_value("reset", "s_tready", 32'd0, 32'(s_udp_payload_tready));
                check_value("reset", "m_hdr_valid", 32'd0, 32'(m_udp_hdr_valid));
                check_value("reset", "m_tvalid", 32'd0, 32'(m_udp_payload_tvalid));
                reset_checked = 1'b1;
            end
            if (led_check) begin
                check_value(cur_name, "led", 32'(led_exp), 32'(led));
                led_check = 1'b0;
            end
            if (!out_started) check_value("before_output", "led", 32'd0, 32'(led));
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                assert (exp_hdr_q.size() != 0) else begin
                    $display("unexpected reply header to port %0d, no reply was due",
                             m_udp_dest_port);
                    proto_errors++;
                end
                if (exp_hdr_q.size() != 0) begin
                    eh = exp_hdr_q.pop_front();
                    cur_name = exp_name_q.pop_front();
                    led_exp = (exp_pay_q.size() != 0) ? exp_pay_q[0][7:0] : 8'h00;
                    check_value(cur_name, "dest_ip", eh[79:48], m_udp_ip_dest_ip);
                    check_value(cur_name, "src_port", 32'(eh[47:32]), 32'(m_udp_source_port));
                    check_value(cur_name, "dst_port", 32'(eh[31:16]), 32'(m_udp_dest_port));
                    check_value(cur_name, "length", 32'(eh[15:0]), 32'(m_udp_length));
                end
            end
            if (m_udp_payload_tvalid && m_udp_payload_tready) begin
                out_started = 1'b1;
                assert (exp_pay_q.size() != 0) else begin
                    $display("unexpected payload byte %0h on the output", m_udp_payload_tdata);
                    proto_errors++;
                end
                if (exp_pay_q.size() != 0) begin
                    ep = exp_pay_q.pop_front();
                    check_value(cur_name, "tdata", 32'(ep[7:0]), 32'(m_udp_payload_tdata));
                    check_value(cur_name, "tlast", 32'(ep[8]), 32'(m_udp_payload_tlast));
                    check_value(cur_name, "tuser", 32'(ep[9]), 32'(m_udp_payload_tuser));
                    if (m_udp_payload_tlast) led_check = 1'b1;
                end
            end
        end
    end

    initial begin
        ip_addr_t  ip;
        udp_port_t sport;
        string     msg;
        s_udp_hdr_valid = 1'b0;
        s_udp_ip_source_ip = '0;
        s_udp_source_port = '0;
        s_udp_dest_port = '0;
        s_udp_length = '0;
        s_udp_payload_tdata = '0;
        s_udp_payload_tvalid = 1'b0;
        s_udp_payload_tlast = 1'b0;
        s_udp_payload_tuser = 1'b0;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        send_datagram("drop", 16'd80, random_word(), udp_port_t'(random_word()),
                      random_length(), 1'b0);

        ip = random_word();
        sport = udp_port_t'(random_word());
        send_datagram("echo", `ECHO_PORT, ip, sport, MAX_LEN, 1'b1);

        // One probe back to the echo sender
        msg = "cutoff check";
        exp_hdr_q.push_back({ip, `ECHO_PORT, sport, udp_len_t'(`UDP_HDR_BYTES + `PROBE_LEN)});
        exp_name_q.push_back("probe");
        for (int i = 0; i < msg.len(); i++) begin
            exp_pay_q.push_back({1'b0, i == msg.len() - 1, byte_t'(msg[i])});
        end

        for (int k = 0; k < NUM_DGRAMS - 2; k++) begin
            send_datagram($sformatf("cutoff_%0d", k), `ECHO_PORT, random_word(),
                          udp_port_t'(random_word()), random_length(), 1'b0);
        end

        while (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0) @(negedge clk);
        repeat (100) @(negedge clk);   // Quiet output expected from here on
        $display("errors: %0d value, %0d protocol, %0d property",
                 value_errors, proto_errors, dut_i.arbiter_i.props_i.prop_failures);
        if (value_errors + proto_errors + dut_i.arbiter_i.props_i.prop_failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (16 + TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out with %0d reply headers and %0d payload bytes still outstanding",
                 exp_hdr_q.size(), exp_pay_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
udp_echo_pkg.sv
echo_filter.sv
probe_source.sv
payload_fifo.sv
reply_arbiter.sv
udp_echo_core.sv
udp_echo_properties.sv
tb_udp_echo.sv

//--- Makefile
# Verilator build and run for the UDP echo core testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL CHECKS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) udp_echo_settings.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
